// File: verilog/vector_bus_pkg.sv
// Vector 06C bus definitions
`default_nettype none

package vector_bus_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int addr_w = 16;
	localparam int data_w = 8;
	localparam int page_w = 3;

	// ----------------------------------------
	// Status word bit positions
	// ----------------------------------------
	localparam int st_int_ack  = 0;
	localparam int st_write_n  = 1;
	localparam int st_io_stack = 2;
	localparam int st_io_write = 4;
	localparam int st_io_read  = 6;
	localparam int st_ram_read = 7;

	// Idle status: write_n high, every other flag low
	localparam logic [data_w-1:0] st_idle_word = 8'h02;

	// ----------------------------------------
	// I/O port codes on the low address byte
	// ----------------------------------------
	// 04 and 05, bit 0 picks whole byte or bit-set command
	localparam logic [7:0] port_joy_ctrl = 8'h04;
	localparam logic [7:0] port_joy_sel  = 8'h06;
	localparam logic [7:0] port_joy_pu   = 8'h07;
	localparam logic [7:0] port_joy_a    = 8'h0E;
	localparam logic [7:0] port_joy_b    = 8'h0F;
	localparam logic [7:0] port_edisk    = 8'h10;

	// Returned for unmapped ports and interrupt acknowledge
	localparam logic [data_w-1:0] io_idle_data = 8'hFF;

endpackage

`default_nettype wire

// File: verilog/vector_joy_pkg.sv
// Vector 06C joystick definitions
`default_nettype none

package vector_joy_pkg;

	// ----------------------------------------
	// Joystick input word bit positions
	// ----------------------------------------
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire1 = 4;
	localparam int joy_fire2 = 5;

	// ----------------------------------------
	// Control register
	// ----------------------------------------
	// Mode field sits in bits 6:5
	localparam int joy_mode_lo = 5;
	localparam int joy_mode_hi = 6;

	// Source of port 06
	localparam logic [1:0] joy_mode_and = 2'b00;
	localparam logic [1:0] joy_mode_a   = 2'b01;
	localparam logic [1:0] joy_mode_b   = 2'b10;
	localparam logic [1:0] joy_mode_off = 2'b11;

	// Bit-set command view of a port 04 write
	typedef struct packed {
		logic       flag;
		logic [2:0] spare;
		logic [2:0] index;
		logic       value;
	} joy_cmd_t;

	typedef union packed {
		logic [7:0] word;
		joy_cmd_t   cmd;
	} joy_ctrl_u;

endpackage

`default_nettype wire

// File: verilog/bus_status_latch.sv
// CPU status word latch
`default_nettype none

module bus_status_latch (
	input  wire                              clk_sys,
	input  wire                              cold_reset,
	input  wire                              cpu_sync_i,
	input  wire [vector_bus_pkg::data_w-1:0] cpu_dout_i,
	output logic                             io_read_o,
	output logic                             io_write_o,
	output logic                             int_ack_o,
	output logic                             io_stack_o,
	output logic                             mem_access_o
);

	logic                              sync_q;
	logic [vector_bus_pkg::data_w-1:0] status_word;

	// Status byte is on the data bus while sync is high
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q      <= 1'b0;
			status_word <= vector_bus_pkg::st_idle_word;
		end else begin
			sync_q <= cpu_sync_i;
			if (cpu_sync_i && !sync_q)
				status_word <= cpu_dout_i;
		end
	end

	// ----------------------------------------
	// Cycle flags
	// ----------------------------------------
	assign io_read_o  = status_word[vector_bus_pkg::st_io_read];
	assign io_write_o = status_word[vector_bus_pkg::st_io_write];
	assign int_ack_o  = status_word[vector_bus_pkg::st_int_ack];
	assign io_stack_o = status_word[vector_bus_pkg::st_io_stack];

	// Memory read or write, not an I/O cycle
	assign mem_access_o = (status_word[vector_bus_pkg::st_ram_read]
		| ~status_word[vector_bus_pkg::st_write_n])
		& ~status_word[vector_bus_pkg::st_io_write]
		& ~status_word[vector_bus_pkg::st_io_read];

endmodule

`default_nettype wire

// File: verilog/io_port_decoder.sv
// I/O port decoder and read mux
`default_nettype none

module io_port_decoder (
	input  wire  [7:0]                        cpu_addr_i,
	input  wire                               cpu_wr_n_i,
	input  wire                               io_read_i,
	input  wire                               io_write_i,
	input  wire                               int_ack_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_sel_data_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_pu_data_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_a_data_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_b_data_i,
	output logic                              edisk_wr_o,
	output logic                              joy_wr_o,
	output logic [vector_bus_pkg::data_w-1:0] cpu_din_o
);

	logic                              io_wr;
	logic                              joy_ctrl_sel;
	logic                              edisk_sel;
	logic [vector_bus_pkg::data_w-1:0] port_data;

	// ----------------------------------------
	// Port selects
	// ----------------------------------------
	// Control port ignores address bit 0
	assign joy_ctrl_sel = (cpu_addr_i[7:1] == vector_bus_pkg::port_joy_ctrl[7:1]);
	assign edisk_sel    = (cpu_addr_i == vector_bus_pkg::port_edisk);

	// OUT cycle with the write pulse low
	assign io_wr = io_write_i & ~cpu_wr_n_i;

	assign edisk_wr_o = io_wr & edisk_sel;
	assign joy_wr_o   = io_wr & joy_ctrl_sel;

	// ----------------------------------------
	// Read data
	// ----------------------------------------
	always_comb begin
		port_data = vector_bus_pkg::io_idle_data;
		case (cpu_addr_i)
			vector_bus_pkg::port_joy_sel:
				port_data = joy_sel_data_i;
			vector_bus_pkg::port_joy_pu:
				port_data = joy_pu_data_i;
			vector_bus_pkg::port_joy_a:
				port_data = joy_a_data_i;
			vector_bus_pkg::port_joy_b:
				port_data = joy_b_data_i;
			// Write-only and unmapped ports float high
			default: ;
		endcase
	end

	// Interrupt acknowledge puts RST 7 on the bus
	always_comb begin
		if (int_ack_i)
			cpu_din_o = vector_bus_pkg::io_idle_data;
		else if (io_read_i)
			cpu_din_o = port_data;
		else
			cpu_din_o = vector_bus_pkg::io_idle_data;
	end

endmodule

`default_nettype wire

// File: verilog/edisk_mapper.sv
// E-disk page mapper
`default_nettype none

module edisk_mapper (
	input  wire                                clk_sys,
	input  wire                                cold_reset,
	input  wire                                edisk_wr_i,
	input  wire  [vector_bus_pkg::data_w-1:0]  cpu_dout_i,
	input  wire  [vector_bus_pkg::addr_w-1:13] cpu_addr_i,
	input  wire                                mem_access_i,
	input  wire                                io_stack_i,
	output logic [vector_bus_pkg::page_w-1:0]  ed_page_o
);

	logic                              wr_q;
	logic [vector_bus_pkg::data_w-1:0] ed_reg;
	logic                              ed_win;
	logic                              ed_ram;
	logic                              ed_stack;

	// Control register, loaded once per write pulse
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			wr_q   <= 1'b0;
			ed_reg <= '0;
		end else begin
			wr_q <= edisk_wr_i;
			if (edisk_wr_i && !wr_q)
				ed_reg <= cpu_dout_i;
		end
	end

	// ----------------------------------------
	// Window and page selection
	// ----------------------------------------
	// A000-DFFF always, 8000-9FFF and E000-FFFF when enabled
	assign ed_win = cpu_addr_i[15] & ((cpu_addr_i[14] ^ cpu_addr_i[13])
		| (ed_reg[7] & cpu_addr_i[14] & cpu_addr_i[13])
		| (ed_reg[6] & ~cpu_addr_i[14] & ~cpu_addr_i[13]));

	assign ed_stack = ed_reg[4] & io_stack_i & mem_access_i;
	assign ed_ram   = ed_reg[5] & ed_win & mem_access_i;

	// Page 0 is main RAM, e-disk banks are 1 to 4
	always_comb begin
		if (ed_stack)
			ed_page_o = {1'b0, ed_reg[3:2]} + 3'd1;
		else if (ed_ram)
			ed_page_o = {1'b0, ed_reg[1:0]} + 3'd1;
		else
			ed_page_o = '0;
	end

endmodule

`default_nettype wire

// File: verilog/joystick_ports.sv
// Joystick control and read ports
`default_nettype none

module joystick_ports (
	input  wire                               clk_sys,
	input  wire                               cold_reset,
	input  wire                               joy_wr_i,
	input  wire                               cpu_addr_i,
	input  wire  [vector_bus_pkg::data_w-1:0] cpu_dout_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_a_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_b_i,
	output logic [vector_bus_pkg::data_w-1:0] joy_ctrl_o,
	output logic [vector_bus_pkg::data_w-1:0] joy_sel_data_o,
	output logic [vector_bus_pkg::data_w-1:0] joy_pu_data_o,
	output logic [vector_bus_pkg::data_w-1:0] joy_a_data_o,
	output logic [vector_bus_pkg::data_w-1:0] joy_b_data_o
);

	logic                              wr_q;
	vector_joy_pkg::joy_ctrl_u         ctrl_wr;
	logic [vector_bus_pkg::data_w-1:0] joy_pu;

	// Active-low stick byte as seen on ports 0E and 0F
	function automatic logic [7:0] fmt_stick(input logic [7:0] j);
		fmt_stick = ~{j[vector_joy_pkg::joy_fire2], j[vector_joy_pkg::joy_fire1], 2'b00,
			j[vector_joy_pkg::joy_down], j[vector_joy_pkg::joy_up],
			j[vector_joy_pkg::joy_left], j[vector_joy_pkg::joy_right]};
	endfunction

	assign ctrl_wr.word = cpu_dout_i;

	// ----------------------------------------
	// Control register
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			wr_q       <= 1'b0;
			joy_ctrl_o <= '0;
		end else begin
			wr_q <= joy_wr_i;
			if (joy_wr_i && !wr_q) begin
				// Port 05 loads the byte and port 04 sets or clears one bit
				if (cpu_addr_i)
					joy_ctrl_o <= ctrl_wr.word;
				else if (!ctrl_wr.cmd.flag)
					joy_ctrl_o[ctrl_wr.cmd.index] <= ctrl_wr.cmd.value;
			end
		end
	end

	// ----------------------------------------
	// Read formats
	// ----------------------------------------
	assign joy_a_data_o = fmt_stick(joy_a_i);
	assign joy_b_data_o = fmt_stick(joy_b_i);

	// Port 07 layout is active high with both sticks merged
	assign joy_pu = joy_a_i | joy_b_i;
	assign joy_pu_data_o = {joy_pu[vector_joy_pkg::joy_up], joy_pu[vector_joy_pkg::joy_right],
		joy_pu[vector_joy_pkg::joy_down], joy_pu[vector_joy_pkg::joy_left],
		joy_pu[vector_joy_pkg::joy_fire1], joy_pu[vector_joy_pkg::joy_fire2], 2'b00};

	always_comb begin
		case (joy_ctrl_o[vector_joy_pkg::joy_mode_hi:vector_joy_pkg::joy_mode_lo])
			vector_joy_pkg::joy_mode_and:
				joy_sel_data_o = joy_a_data_o & joy_b_data_o;
			vector_joy_pkg::joy_mode_a:
				joy_sel_data_o = joy_a_data_o;
			vector_joy_pkg::joy_mode_b:
				joy_sel_data_o = joy_b_data_o;
			vector_joy_pkg::joy_mode_off:
				joy_sel_data_o = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/vector06_io_top.sv
// Vector 06C I/O and bank control
`default_nettype none

module vector06_io_top (
	input  wire                               clk_sys,
	input  wire                               cold_reset,
	input  wire  [vector_bus_pkg::addr_w-1:0] cpu_addr_i,
	input  wire  [vector_bus_pkg::data_w-1:0] cpu_dout_i,
	input  wire                               cpu_sync_i,
	// DBIN from the CPU
	input  wire                               cpu_rd_i,
	input  wire                               cpu_wr_n_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_a_i,
	input  wire  [vector_bus_pkg::data_w-1:0] joy_b_i,
	output logic [vector_bus_pkg::data_w-1:0] cpu_din_o,
	output logic [vector_bus_pkg::page_w-1:0] ed_page_o,
	output logic [vector_bus_pkg::data_w-1:0] joy_ctrl_o
);

	// Cycle flags
	logic io_read;
	logic io_write;
	logic int_ack;
	logic io_stack;
	logic mem_access;

	// Write strobes
	logic edisk_wr;
	logic joy_wr;

	// Joystick read bytes
	logic [vector_bus_pkg::data_w-1:0] joy_sel_data;
	logic [vector_bus_pkg::data_w-1:0] joy_pu_data;
	logic [vector_bus_pkg::data_w-1:0] joy_a_data;
	logic [vector_bus_pkg::data_w-1:0] joy_b_data;

	// ----------------------------------------
	// Bus side
	// ----------------------------------------
	bus_status_latch u_status (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.cpu_sync_i   (cpu_sync_i),
		.cpu_dout_i   (cpu_dout_i),
		.io_read_o    (io_read),
		.io_write_o   (io_write),
		.int_ack_o    (int_ack),
		.io_stack_o   (io_stack),
		.mem_access_o (mem_access)
	);

	io_port_decoder u_decoder (
		.cpu_addr_i     (cpu_addr_i[7:0]),
		.cpu_wr_n_i     (cpu_wr_n_i),
		.io_read_i      (io_read),
		.io_write_i     (io_write),
		.int_ack_i      (int_ack),
		.joy_sel_data_i (joy_sel_data),
		.joy_pu_data_i  (joy_pu_data),
		.joy_a_data_i   (joy_a_data),
		.joy_b_data_i   (joy_b_data),
		.edisk_wr_o     (edisk_wr),
		.joy_wr_o       (joy_wr),
		.cpu_din_o      (cpu_din_o)
	);

	// ----------------------------------------
	// Registers
	// ----------------------------------------
	edisk_mapper u_edisk (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.edisk_wr_i   (edisk_wr),
		.cpu_dout_i   (cpu_dout_i),
		.cpu_addr_i   (cpu_addr_i[vector_bus_pkg::addr_w-1:13]),
		.mem_access_i (mem_access),
		.io_stack_i   (io_stack),
		.ed_page_o    (ed_page_o)
	);

	joystick_ports u_joy (
		.clk_sys        (clk_sys),
		.cold_reset     (cold_reset),
		.joy_wr_i       (joy_wr),
		.cpu_addr_i     (cpu_addr_i[0]),
		.cpu_dout_i     (cpu_dout_i),
		.joy_a_i        (joy_a_i),
		.joy_b_i        (joy_b_i),
		.joy_ctrl_o     (joy_ctrl_o),
		.joy_sel_data_o (joy_sel_data),
		.joy_pu_data_o  (joy_pu_data),
		.joy_a_data_o   (joy_a_data),
		.joy_b_data_o   (joy_b_data)
	);

endmodule

`default_nettype wire

// File: test/tb_vector06_io_table.svh
// Vector 06C I/O stimulus table
`ifndef TB_VECTOR06_IO_TABLE_SVH
`define TB_VECTOR06_IO_TABLE_SVH

	// Status bytes for each kind of machine cycle
	localparam logic [7:0] s_in    = 8'h42;
	localparam logic [7:0] s_out   = 8'h10;
	localparam logic [7:0] s_mrd   = 8'h82;
	localparam logic [7:0] s_mwr   = 8'h00;
	localparam logic [7:0] s_srd   = 8'h86;
	localparam logic [7:0] s_swr   = 8'h04;
	localparam logic [7:0] s_fetch = 8'hA2;
	// Acknowledge with the read flag also set
	localparam logic [7:0] s_inta  = 8'h43;

	// Whole-byte control values that pick a port 06 source
	localparam logic [7:0] mode_a_byte = {1'b0, vector_joy_pkg::joy_mode_a, 5'b00000};
	localparam logic [7:0] mode_b_byte = {1'b0, vector_joy_pkg::joy_mode_b, 5'b00000};

	typedef struct packed {
		logic [7:0]  status;
		logic [15:0] addr;
		logic [7:0]  data;
		logic        wr;
		logic [7:0]  joy_a;
		logic [7:0]  joy_b;
		logic [7:0]  exp_din;
		logic [2:0]  exp_page;
		logic [7:0]  exp_ctrl;
		logic        rst;
	} row_t;

	localparam int num_rows = 50;

	// status, addr, data, wr, joy_a, joy_b, din, page, ctrl, reset first
	localparam row_t rows [num_rows] = '{
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h01, 8'h04, 8'hF6, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0E0E, 8'h00, 1'b0, 8'h01, 8'h00, 8'hFE, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0E0E, 8'h00, 1'b0, 8'h3F, 8'h00, 8'h30, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0E0E, 8'h00, 1'b0, 8'h25, 8'h00, 8'h76, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0F0F, 8'h00, 1'b0, 8'h00, 8'h04, 8'hF7, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0F0F, 8'h00, 1'b0, 8'h00, 8'h1A, 8'hB9, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0F0F, 8'h00, 1'b0, 8'h00, 8'hC0, 8'hFF, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0707, 8'h00, 1'b0, 8'h25, 8'h00, 8'h64, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0707, 8'h00, 1'b0, 8'h1A, 8'h04, 8'hB8, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'h0707, 8'h00, 1'b0, 8'h10, 8'h02, 8'h18, 3'd0, 8'h00, 1'b0},
		'{s_in,    16'hFF0E, 8'h00, 1'b0, 8'h01, 8'h00, 8'hFE, 3'd0, 8'h00, 1'b0},
		'{s_out,   16'h0505, mode_a_byte, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h20, 1'b0},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'h76, 3'd0, 8'h20, 1'b0},
		'{s_out,   16'h0505, mode_b_byte, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h40, 1'b0},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'hB9, 3'd0, 8'h40, 1'b0},
		'{s_out,   16'h0505, 8'h6B, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h6B, 1'b0},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h6B, 1'b0},
		'{s_out,   16'h0404, 8'h0C, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h2B, 1'b0},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'h76, 3'd0, 8'h2B, 1'b0},
		'{s_out,   16'h0404, 8'h09, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h3B, 1'b0},
		'{s_out,   16'h0404, 8'h00, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h3A, 1'b0},
		'{s_out,   16'h0404, 8'h8D, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h3A, 1'b0},
		'{s_out,   16'h0404, 8'h0A, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h1A, 1'b0},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'h30, 3'd0, 8'h1A, 1'b0},
		'{s_out,   16'h0404, 8'h0F, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_out,   16'h0606, 8'h60, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_mwr,   16'h0005, 8'h6B, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_out,   16'h1010, 8'h21, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_mrd,   16'hA000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd2, 8'h9A, 1'b0},
		'{s_mwr,   16'hC123, 8'h55, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd2, 8'h9A, 1'b0},
		'{s_mrd,   16'h8000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_out,   16'h1010, 8'h6E, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_mrd,   16'h8000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd3, 8'h9A, 1'b0},
		'{s_mwr,   16'hFFFF, 8'hAA, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_fetch, 16'h7FFF, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_swr,   16'h1234, 8'h00, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_out,   16'h1010, 8'h17, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_swr,   16'h1234, 8'h00, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd2, 8'h9A, 1'b0},
		'{s_mrd,   16'hA000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_out,   16'h1010, 8'hBC, 1'b1, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_srd,   16'hC000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd4, 8'h9A, 1'b0},
		'{s_mrd,   16'hE000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd1, 8'h9A, 1'b0},
		'{s_in,    16'h1010, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_in,    16'h5555, 8'h00, 1'b0, 8'h01, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_inta,  16'h0E0E, 8'h00, 1'b0, 8'h01, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_mrd,   16'h0E0E, 8'h00, 1'b0, 8'h01, 8'h00, 8'hFF, 3'd0, 8'h9A, 1'b0},
		'{s_mrd,   16'hC000, 8'h00, 1'b0, 8'h00, 8'h00, 8'hFF, 3'd0, 8'h00, 1'b1},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'h30, 3'd0, 8'h00, 1'b0},
		'{s_out,   16'h0505, mode_a_byte, 1'b1, 8'h25, 8'h1A, 8'hFF, 3'd0, 8'h20, 1'b0},
		'{s_in,    16'h0606, 8'h00, 1'b0, 8'h25, 8'h1A, 8'h76, 3'd0, 8'h20, 1'b0}
	};

`endif

// File: test/tb_vector06_io.sv
// Vector 06C I/O testbench
`default_nettype none

module tb_vector06_io;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 100;
	localparam int reset_cycles = 8;

	logic                              clk_sys;
	logic                              cold_reset;
	logic [vector_bus_pkg::addr_w-1:0] cpu_addr_i;
	logic [vector_bus_pkg::data_w-1:0] cpu_dout_i;
	logic                              cpu_sync_i;
	logic                              cpu_rd_i;
	logic                              cpu_wr_n_i;
	logic [vector_bus_pkg::data_w-1:0] joy_a_i;
	logic [vector_bus_pkg::data_w-1:0] joy_b_i;
	logic [vector_bus_pkg::data_w-1:0] cpu_din_o;
	logic [vector_bus_pkg::page_w-1:0] ed_page_o;
	logic [vector_bus_pkg::data_w-1:0] joy_ctrl_o;

	`include "tb_vector06_io_table.svh"

	vector06_io_top UUT (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_addr_i (cpu_addr_i),
		.cpu_dout_i (cpu_dout_i),
		.cpu_sync_i (cpu_sync_i),
		.cpu_rd_i   (cpu_rd_i),
		.cpu_wr_n_i (cpu_wr_n_i),
		.joy_a_i    (joy_a_i),
		.joy_b_i    (joy_b_i),
		.cpu_din_o  (cpu_din_o),
		.ed_page_o  (ed_page_o),
		.joy_ctrl_o (joy_ctrl_o)
	);

	// ----------------------------------------
	// Clock and watchdog
	// ----------------------------------------
	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// Ten cycles per row is well above the real row length
	initial begin
		#((num_rows * 10 + reset_cycles) * clk_period);
		$display("Timeout: the table did not finish in the expected time");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	task automatic check_byte(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		assert (actual === expected) else begin
			$display("ERR at %0d ns: %s expected %02h actual %02h",
				$time, name, expected, actual);
			$display("Test failures found");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Status phase, data phase, one settle cycle, then compare
	task automatic apply_row(input int idx);
		row_t r;
		r = rows[idx];
		if (r.rst) begin
			cold_reset = 1'b1;
			repeat (reset_cycles) @(negedge clk_sys);
			cold_reset = 1'b0;
		end
		cpu_dout_i = r.status;
		cpu_sync_i = 1'b1;
		@(negedge clk_sys);
		cpu_sync_i = 1'b0;
		cpu_addr_i = r.addr;
		cpu_dout_i = r.data;
		cpu_wr_n_i = !r.wr;
		cpu_rd_i   = !r.wr;
		joy_a_i    = r.joy_a;
		joy_b_i    = r.joy_b;
		@(negedge clk_sys);
		cpu_wr_n_i = 1'b1;
		cpu_rd_i   = 1'b0;
		@(negedge clk_sys);
		check_byte("cpu_din_o", cpu_din_o, r.exp_din);
		check_byte("ed_page_o", {5'b00000, ed_page_o}, {5'b00000, r.exp_page});
		check_byte("joy_ctrl_o", joy_ctrl_o, r.exp_ctrl);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		cold_reset = 1'b1;
		cpu_addr_i = '0;
		cpu_dout_i = '0;
		cpu_sync_i = 1'b0;
		cpu_rd_i   = 1'b0;
		cpu_wr_n_i = 1'b1;
		joy_a_i    = '0;
		joy_b_i    = '0;
		repeat (reset_cycles) @(negedge clk_sys);
		cold_reset = 1'b0;

		for (int i = 0; i < num_rows; i++) begin
			apply_row(i);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
verilog/vector_bus_pkg.sv
verilog/vector_joy_pkg.sv
verilog/bus_status_latch.sv
verilog/io_port_decoder.sv
verilog/edisk_mapper.sv
verilog/joystick_ports.sv
verilog/vector06_io_top.sv
test/tb_vector06_io.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vector06_io
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
